// ==== list.f ====
logic/fdc_pkg.sv
logic/fdc_ram.sv
logic/fdc_mem_arbiter.sv
logic/fdc_bus_decoder.sv
logic/fdc_tx_streamer.sv
logic/uart_tx.sv
logic/fdc_top.sv
sim/fdc_checker.sv
sim/fdc_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fdc_tb -f list.f

./obj_dir/Vfdc_tb > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
exit 0

// ==== sim/fdc_tb.sv ====
`timescale 1ns/1ns

module fdc_tb;
	import fdc_pkg::*;

	localparam logic [15:0] IOBASE = 16'hE000;
	localparam int CLK_NS = 4;
	localparam int BIT_NS = 4 * CLK_NS;
	// One direct byte, then streams of 20 and 30 bytes
	localparam int STREAM_BYTES = 51;
	localparam int WATCHDOG_NS = STREAM_BYTES * 10 * BIT_NS + 20000;

	logic       clk;
	logic       reset_n;
	host_req_t  host;
	logic [7:0] rd_data;
	logic       rd_valid;
	logic [7:0] leds;
	logic       txd;

	logic [7:0]  zp_shadow [0:511];
	logic [7:0]  buf_shadow [0:2047];
	logic [15:0] written_q [$];
	logic [7:0]  exp_q [$];
	logic [7:0]  rx_q [$];
	event        byte_rx;
	integer      seed = 75262;
	int          error_count = 0;
	int          check_count = 0;
	int          rx_count = 0;

	fdc_top #(.IOBASE(IOBASE), .CLKS_PER_BIT(16'd4)) UUT (
		.clk(clk), .reset_n(reset_n), .host(host),
		.rd_data(rd_data), .rd_valid(rd_valid), .leds(leds), .txd(txd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [15:0] port_addr(input logic [7:0] off);
		return IOBASE + {8'd0, off};
	endfunction

	// Expected host read byte, straight from the memory map
	function automatic logic [7:0] expected_read(input logic [15:0] addr);
		if (addr >= 16'hFFFC) begin
			return addr[0] ? 8'h08 : 8'h00;
		end else if (addr < 16'h0200) begin
			return zp_shadow[addr[8:0]];
		end else if (addr >= BUF_BASE && addr < BUF_BASE + BUF_SIZE) begin
			return buf_shadow[addr[10:0]];
		end
		return 8'hFF;
	endfunction

	// ----------------------------------------
	// Host bus tasks
	// ----------------------------------------
	task automatic host_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		host = {1'b1, 1'b1, addr, data};
		@(posedge clk);
		#1;
		host = '0;
		if (addr < 16'h0200) begin
			zp_shadow[addr[8:0]] = data;
		end else if (addr >= BUF_BASE && addr < BUF_BASE + BUF_SIZE) begin
			buf_shadow[addr[10:0]] = data;
		end
	endtask

	// Response is sampled one cycle after the strobe
	task automatic host_read(input logic [15:0] addr, output logic [7:0] data,
		output logic valid);
		@(posedge clk);
		#1;
		host = {1'b1, 1'b0, addr, 8'h00};
		@(posedge clk);
		#1;
		host = '0;
		data = rd_data;
		valid = rd_valid;
	endtask

	task automatic check_read(input logic [15:0] addr);
		logic [7:0] d;
		logic       v;
		logic [7:0] want;
		want = expected_read(addr);
		host_read(addr, d, v);
		check_count++;
		if (!v) begin
			error_count++;
			$display("No read response one cycle after the strobe to %h at %0t", addr, $time);
		end else if (d !== want) begin
			error_count++;
			$display("Fail %0t: read %h returned %h, expected %h", $time, addr, d, want);
		end
	endtask

	task automatic read_status(output logic [7:0] st);
		logic v;
		host_read(port_addr(PORT_CTL), st, v);
		if (!v) begin
			error_count++;
			$display("No read response from the status port at %0t", $time);
		end
	endtask

	task automatic wait_idle(input logic [7:0] mask);
		logic [7:0] st;
		read_status(st);
		while ((st & mask) != 8'd0) begin
			read_status(st);
		end
	endtask

	task automatic fill_buffer(input logic [10:0] start, input int count);
		logic [10:0] off;
		for (int i = 0; i < count; i++) begin
			off = start + 11'(i);
			host_write(BUF_BASE + {5'd0, off}, 8'($random(seed)));
		end
	endtask

	// Expected bytes wrap modulo the buffer size
	task automatic start_stream(input logic [10:0] start, input int count);
		logic [7:0] st;
		for (int i = 0; i < count; i++) begin
			exp_q.push_back(buf_shadow[start + 11'(i)]);
		end
		host_write(port_addr(PORT_SLO), start[7:0]);
		host_write(port_addr(PORT_SHI), {5'd0, start[10:8]});
		host_write(port_addr(PORT_LEN), 8'(count));
		read_status(st);
		check_count++;
		if (st[1] !== 1'b1) begin
			error_count++;
			$display("Fail %0t: status %h shows no stream after start", $time, st);
		end
	endtask

	// ----------------------------------------
	// Serial receiver and byte compare
	// ----------------------------------------
	initial begin : serial_rx
		logic [7:0] rx_byte;
		forever begin
			@(negedge txd);
			#(BIT_NS / 2);
			for (int i = 0; i < 8; i++) begin
				#(BIT_NS);
				rx_byte[i] = txd;
			end
			#(BIT_NS);
			if (txd !== 1'b1) begin
				error_count++;
				$display("Missing stop bit on txd at %0t", $time);
			end
			rx_q.push_back(rx_byte);
			-> byte_rx;
		end
	end

	initial begin : compare_rx
		logic [7:0] got;
		logic [7:0] want;
		forever begin
			@(byte_rx);
			while (rx_q.size() > 0) begin
				got = rx_q.pop_front();
				rx_count++;
				check_count++;
				if (exp_q.size() == 0) begin
					error_count++;
					$display("Unexpected byte %h arrived on txd at %0t", got, $time);
				end else begin
					want = exp_q.pop_front();
					if (got !== want) begin
						error_count++;
						$display("Fail %0t: txd byte %h, expected %h", $time, got, want);
					end
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin : main_seq
		logic [7:0]  d;
		logic [7:0]  st;
		logic [15:0] a;
		logic [31:0] r;
		host = '0;
		reset_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// Random writes over zero page and buffer, then read back
		repeat (300) begin
			r = $random(seed);
			a = r[0] ? {7'd0, r[9:1]} : BUF_BASE + {5'd0, r[11:1]};
			host_write(a, r[23:16]);
			written_q.push_back(a);
		end
		repeat (300) begin
			r = $random(seed);
			check_read(written_q[r % written_q.size()]);
		end

		// Boot vector, unmapped space, unused ports
		for (int i = 0; i < 4; i++) begin
			check_read(16'hFFFC + 16'(i));
		end
		check_read(16'h0400);
		check_read(16'h2000);
		check_read(port_addr(8'd0));
		check_read(port_addr(PORT_LED));
		host_write(port_addr(PORT_LED), 8'h5A);
		check_count++;
		if (leds !== 8'h5A) begin
			error_count++;
			$display("Fail %0t: leds %h, expected 5a", $time, leds);
		end

		// Direct byte, second write lands while busy and is dropped
		d = 8'($random(seed));
		exp_q.push_back(d);
		host_write(port_addr(PORT_TXD), d);
		read_status(st);
		check_count++;
		if (st[0] !== 1'b1) begin
			error_count++;
			$display("Fail %0t: status %h shows UART idle while sending", $time, st);
		end
		host_write(port_addr(PORT_TXD), ~d);
		wait_idle(8'h01);

		// Stream that wraps past the buffer end
		fill_buffer(11'd2040, 20);
		start_stream(11'd2040, 20);
		wait_idle(8'h02);

		// Stream with the host hammering the buffer
		fill_buffer(11'd100, 30);
		start_stream(11'd100, 30);
		repeat (200) begin
			r = $random(seed);
			a = BUF_BASE + 16'd512 + {7'd0, r[8:0]};
			if (r[9]) begin
				host_write(a, r[23:16]);
				written_q.push_back(a);
			end else begin
				check_read(written_q[r % written_q.size()]);
			end
		end
		wait_idle(8'h02);

		repeat (10) @(posedge clk);
		check_count++;
		if (exp_q.size() != 0) begin
			error_count++;
			$display("%0d expected bytes never arrived on txd", exp_q.size());
		end
		$display("Checks %0d, bytes received %0d, errors %0d", check_count, rx_count,
			error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== sim/fdc_checker.sv ====
`timescale 1ns/1ns

module fdc_checker (
	input fdc_pkg::mem_req_t host_mem,
	input fdc_pkg::mem_req_t strm_mem,
	input logic              strm_grant,
	input logic              buf_we
);

	logic smp;

	// Sampling strobe, rises midway between the 4 ns clock edges
	initial begin
		smp = 1'b1;
		forever #2 smp = ~smp;
	end

	// A waiting streamer request keeps its address until granted
	req_held: assert property (@(posedge smp) (strm_mem.valid && !strm_grant) |=>
		(strm_mem.valid && $stable(strm_mem.addr)))
		else $error("streamer request dropped or moved before its grant");

	// One read per grant, the data comes back the next cycle
	one_read_per_grant: assert property (@(posedge smp) strm_grant |=> !strm_mem.valid)
		else $error("streamer asked again in the cycle its data returns");

	// Only the host writes the sector buffer
	host_only_writes: assert property (@(posedge smp) buf_we |->
		(host_mem.valid && host_mem.write))
		else $error("buffer write without a host write request");

endmodule

bind fdc_mem_arbiter fdc_checker u_checker (
	.host_mem(host_mem), .strm_mem(strm_mem), .strm_grant(strm_grant), .buf_we(buf_we)
);

// ==== logic/fdc_top.sv ====
`timescale 1ns/1ns

module fdc_top #(
	parameter logic [15:0] IOBASE       = 16'hE000,
	parameter logic [15:0] CLKS_PER_BIT = 16'd16
) (
	input  logic               clk,
	input  logic               reset_n,
	input  fdc_pkg::host_req_t host,
	output logic [7:0]         rd_data,
	output logic               rd_valid,
	output logic [7:0]         leds,
	output logic               txd
);
	import fdc_pkg::*;

	logic        zp_we;
	logic [8:0]  zp_addr;
	logic [7:0]  zp_wdata;
	logic [7:0]  zp_rdata;
	mem_req_t    host_mem;
	mem_req_t    strm_mem;
	stream_cmd_t cmd;
	logic        strm_grant;
	logic        buf_we;
	logic [10:0] buf_addr;
	logic [7:0]  buf_wdata;
	logic [7:0]  buf_rdata;
	logic        tx_load_host;
	logic [7:0]  tx_byte_host;
	logic        tx_load;
	logic [7:0]  tx_byte;
	logic        tx_busy;
	logic        strm_busy;

	fdc_bus_decoder #(.IOBASE(IOBASE)) u_decoder (
		.clk(clk), .reset_n(reset_n), .host(host),
		.zp_we(zp_we), .zp_addr(zp_addr), .zp_wdata(zp_wdata), .zp_rdata(zp_rdata),
		.host_mem(host_mem), .buf_rdata(buf_rdata), .cmd(cmd),
		.tx_load_host(tx_load_host), .tx_byte_host(tx_byte_host),
		.tx_busy(tx_busy), .strm_busy(strm_busy),
		.rd_data(rd_data), .rd_valid(rd_valid), .leds(leds)
	);

	// Zero page and sector buffer
	fdc_ram #(.ADDR_W(9)) u_zp_ram (
		.clk(clk), .we(zp_we), .addr(zp_addr), .wdata(zp_wdata), .rdata(zp_rdata)
	);

	fdc_ram #(.ADDR_W(11)) u_buf_ram (
		.clk(clk), .we(buf_we), .addr(buf_addr), .wdata(buf_wdata), .rdata(buf_rdata)
	);

	fdc_mem_arbiter u_arbiter (
		.host_mem(host_mem), .strm_mem(strm_mem), .strm_grant(strm_grant),
		.buf_we(buf_we), .buf_addr(buf_addr), .buf_wdata(buf_wdata)
	);

	fdc_tx_streamer u_streamer (
		.clk(clk), .reset_n(reset_n), .cmd(cmd),
		.strm_mem(strm_mem), .strm_grant(strm_grant), .buf_rdata(buf_rdata),
		.tx_load_host(tx_load_host), .tx_byte_host(tx_byte_host), .tx_busy(tx_busy),
		.tx_load(tx_load), .tx_byte(tx_byte), .strm_busy(strm_busy)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
		.clk(clk), .reset_n(reset_n), .tx_load(tx_load), .tx_byte(tx_byte),
		.txd(txd), .tx_busy(tx_busy)
	);

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
	parameter logic [15:0] CLKS_PER_BIT = 16'd4
) (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       tx_load,
	input  logic [7:0] tx_byte,
	output logic       txd,
	output logic       tx_busy
);

	logic [15:0] baud_cnt;
	logic [3:0]  bit_cnt;
	logic [9:0]  frame;

	// Stop, data LSB first, start
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			frame    <= '1;
			baud_cnt <= 16'd0;
			bit_cnt  <= 4'd0;
			tx_busy  <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_load) begin
				frame    <= {1'b1, tx_byte, 1'b0};
				baud_cnt <= 16'd0;
				bit_cnt  <= 4'd0;
				tx_busy  <= 1'b1;
			end
		end else if (baud_cnt == CLKS_PER_BIT - 16'd1) begin
			baud_cnt <= 16'd0;
			// Idle level fills in behind
			frame    <= {1'b1, frame[9:1]};
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + 16'd1;
		end
	end

	assign txd = frame[0];

endmodule

// ==== logic/fdc_tx_streamer.sv ====
`timescale 1ns/1ns

module fdc_tx_streamer (
	input  logic                 clk,
	input  logic                 reset_n,
	input  fdc_pkg::stream_cmd_t cmd,
	output fdc_pkg::mem_req_t    strm_mem,
	input  logic                 strm_grant,
	input  logic [7:0]           buf_rdata,
	input  logic                 tx_load_host,
	input  logic [7:0]           tx_byte_host,
	input  logic                 tx_busy,
	output logic                 tx_load,
	output logic [7:0]           tx_byte,
	output logic                 strm_busy
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_REQ  = 3'd1;
	localparam logic [2:0] S_DATA = 3'd2;
	localparam logic [2:0] S_WAIT = 3'd3;
	localparam logic [2:0] S_LOAD = 3'd4;

	logic [2:0]  state;
	logic [10:0] offset;
	logic [7:0]  remaining;
	logic [7:0]  byte_r;

	// ----------------------------------------
	// Stream FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state     <= S_IDLE;
			offset    <= 11'd0;
			remaining <= 8'd0;
		end else begin
			case (state)
				S_IDLE: if (cmd.go) begin
					offset    <= cmd.start;
					remaining <= cmd.count;
					state     <= S_REQ;
				end
				// Hold the request until the host leaves the port
				S_REQ: if (strm_grant) state <= S_DATA;
				S_DATA: state <= S_WAIT;
				// Also drains the last frame before going idle
				S_WAIT: if (!tx_busy) state <= (remaining == 8'd0) ? S_IDLE : S_LOAD;
				S_LOAD: begin
					offset    <= offset + 11'd1;
					remaining <= remaining - 8'd1;
					state     <= (remaining == 8'd1) ? S_WAIT : S_REQ;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Buffer byte arrives the cycle after the grant
	always_ff @(posedge clk) begin
		if (state == S_DATA) begin
			byte_r <= buf_rdata;
		end
	end

	assign strm_mem  = '{valid: state == S_REQ, write: 1'b0, addr: offset, data: 8'h00};
	assign strm_busy = (state != S_IDLE);

	// Host byte shares the single UART loader
	assign tx_load = (state == S_LOAD) || tx_load_host;
	assign tx_byte = (state == S_LOAD) ? byte_r : tx_byte_host;

endmodule

// ==== logic/fdc_bus_decoder.sv ====
`timescale 1ns/1ns

module fdc_bus_decoder #(
	parameter logic [15:0] IOBASE = 16'hE000
) (
	input  logic                 clk,
	input  logic                 reset_n,
	input  fdc_pkg::host_req_t   host,
	output logic                 zp_we,
	output logic [8:0]           zp_addr,
	output logic [7:0]           zp_wdata,
	input  logic [7:0]           zp_rdata,
	output fdc_pkg::mem_req_t    host_mem,
	input  logic [7:0]           buf_rdata,
	output fdc_pkg::stream_cmd_t cmd,
	output logic                 tx_load_host,
	output logic [7:0]           tx_byte_host,
	input  logic                 tx_busy,
	input  logic                 strm_busy,
	output logic [7:0]           rd_data,
	output logic                 rd_valid,
	output logic [7:0]           leds
);
	import fdc_pkg::*;

	localparam logic [1:0] SEL_ZP  = 2'd0;
	localparam logic [1:0] SEL_BUF = 2'd1;
	localparam logic [1:0] SEL_REG = 2'd2;

	logic        boot_sel;
	logic        zp_sel;
	logic        buf_sel;
	logic        io_sel;
	logic [15:0] buf_off;
	logic [15:0] io_off;
	logic        rd_stb;
	logic        io_wr;
	logic [1:0]  rd_sel;
	logic [7:0]  reg_rdata;
	logic [7:0]  slo_r;
	logic [2:0]  shi_r;

	// ----------------------------------------
	// Region decode, boot vector wins
	// ----------------------------------------
	assign boot_sel = &host.addr[15:2];
	assign zp_sel   = !boot_sel && (host.addr[15:9] == 7'd0);
	assign buf_off  = host.addr - BUF_BASE;
	assign buf_sel  = !boot_sel && (host.addr >= BUF_BASE) && (buf_off < BUF_SIZE);
	assign io_off   = host.addr - IOBASE;
	assign io_sel   = !boot_sel && (host.addr >= IOBASE) && (io_off < 16'd256);

	assign rd_stb = host.strobe && !host.write;
	assign io_wr  = host.strobe && host.write && io_sel;

	assign zp_we    = host.strobe && host.write && zp_sel;
	assign zp_addr  = host.addr[8:0];
	assign zp_wdata = host.wdata;

	assign host_mem = '{valid: host.strobe && buf_sel, write: host.write,
		addr: buf_off[10:0], data: host.wdata};

	// Direct transmit only when nobody else owns the UART
	assign tx_load_host = io_wr && (io_off[7:0] == PORT_TXD) && !tx_busy && !strm_busy;
	assign tx_byte_host = host.wdata;

	// Zero count starts nothing
	assign cmd = '{go: io_wr && (io_off[7:0] == PORT_LEN) && !strm_busy && (host.wdata != 8'd0),
		start: {shi_r, slo_r}, count: host.wdata};

	// LED latch and stream offset
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			leds  <= 8'd0;
			slo_r <= 8'd0;
			shi_r <= 3'd0;
		end else if (io_wr) begin
			case (io_off[7:0])
				PORT_LED: leds  <= host.wdata;
				PORT_SLO: slo_r <= host.wdata;
				PORT_SHI: shi_r <= host.wdata[2:0];
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Read path
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_valid <= 1'b0;
			rd_sel   <= SEL_REG;
		end else begin
			rd_valid <= rd_stb;
			if (rd_stb) begin
				rd_sel <= zp_sel ? SEL_ZP : (buf_sel ? SEL_BUF : SEL_REG);
			end
		end
	end

	// Boot vector, status and unmapped bytes
	always_ff @(posedge clk) begin
		if (rd_stb) begin
			if (boot_sel) begin
				reg_rdata <= host.addr[0] ? 8'h08 : 8'h00;
			end else if (io_sel && (io_off[7:0] == PORT_CTL)) begin
				reg_rdata <= {6'd0, strm_busy, tx_busy};
			end else begin
				reg_rdata <= 8'hFF;
			end
		end
	end

	always_comb begin
		case (rd_sel)
			SEL_ZP:  rd_data = zp_rdata;
			SEL_BUF: rd_data = buf_rdata;
			default: rd_data = reg_rdata;
		endcase
	end

endmodule

// ==== logic/fdc_mem_arbiter.sv ====
`timescale 1ns/1ns

module fdc_mem_arbiter (
	input  fdc_pkg::mem_req_t host_mem,
	input  fdc_pkg::mem_req_t strm_mem,
	output logic              strm_grant,
	output logic              buf_we,
	output logic [10:0]       buf_addr,
	output logic [7:0]        buf_wdata
);

	logic host_wins;

	// Host has fixed priority, the streamer only gets idle cycles
	assign host_wins  = host_mem.valid;
	assign strm_grant = strm_mem.valid && !host_wins;

	// ----------------------------------------
	// Buffer port mux
	// ----------------------------------------
	always_comb begin
		if (host_wins) begin
			buf_we    = host_mem.write;
			buf_addr  = host_mem.addr;
			buf_wdata = host_mem.data;
		end else begin
			// No write unless the streamer really asks for one
			buf_we    = strm_mem.valid && strm_mem.write;
			buf_addr  = strm_mem.addr;
			buf_wdata = strm_mem.data;
		end
	end

endmodule

// ==== logic/fdc_ram.sv ====
`timescale 1ns/1ns

module fdc_ram #(
	parameter int ADDR_W = 9
) (
	input  logic              clk,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        wdata,
	output logic [7:0]        rdata
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [7:0] mem [0:DEPTH-1];

	// Write at the edge, read data registered for the next cycle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// ==== logic/fdc_pkg.sv ====
package fdc_pkg;

	// ----------------------------------------
	// Bus records
	// ----------------------------------------

	// One host access, 26 bits
	typedef struct packed {
		logic        strobe;
		logic        write;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} host_req_t;

	// One sector buffer request, 21 bits
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [10:0] addr;
		logic [7:0]  data;
	} mem_req_t;

	// Stream start, 20 bits
	typedef struct packed {
		logic        go;
		logic [10:0] start;
		logic [7:0]  count;
	} stream_cmd_t;

	// ----------------------------------------
	// I/O page offsets, relative to IOBASE
	// ----------------------------------------
	localparam logic [7:0] PORT_TXD = 8'd4;
	localparam logic [7:0] PORT_CTL = 8'd6;
	localparam logic [7:0] PORT_SLO = 8'd8;
	localparam logic [7:0] PORT_SHI = 8'd9;
	localparam logic [7:0] PORT_LEN = 8'd10;
	localparam logic [7:0] PORT_LED = 8'd16;

	// Sector buffer window
	localparam logic [15:0] BUF_BASE = 16'h0800;
	localparam logic [15:0] BUF_SIZE = 16'd2048;

endpackage
